/* ddr_bridge_config.svh */
`ifndef DDR_BRIDGE_CONFIG_SVH
`define DDR_BRIDGE_CONFIG_SVH

// bus widths
`define DDR_DATA_WIDTH 128
`define DDR_ADDR_WIDTH 32           // byte address in, word address out
`define DDR_ID_WIDTH 8
`define DDR_STRB_WIDTH 16           // one bit per data byte

// queue depths
`define DDR_CMD_FIFO_DEPTH 16
`define DDR_TAG_FIFO_DEPTH 16       // caps outstanding reads
`define DDR_RD_FIFO_DEPTH 16        // keep >= tag depth, read data has no back-pressure

`endif

/* ddr_bridge_pkg.sv */
`include "ddr_bridge_config.svh"

package ddr_bridge_pkg;

    // command as it arrives from the ram side
    typedef struct packed {
        logic [`DDR_ID_WIDTH-1:0]   id;
        logic [`DDR_ADDR_WIDTH-1:0] addr;      // byte address
        logic [`DDR_DATA_WIDTH-1:0] wr_data;
        logic [`DDR_STRB_WIDTH-1:0] wr_strb;   // 1 = byte written
        logic                       rd;
        logic                       last;
    } ram_cmd_t;

    // queued form, already in controller encoding
    typedef struct packed {
        logic [`DDR_ID_WIDTH-1:0]   id;
        logic [`DDR_ADDR_WIDTH-1:0] addr;      // word address
        logic [`DDR_DATA_WIDTH-1:0] wr_data;
        logic [`DDR_STRB_WIDTH-1:0] wr_mask;   // 1 = byte kept
        logic                       rd;
        logic                       last;
    } app_cmd_t;

    typedef struct packed {
        logic [`DDR_ADDR_WIDTH-1:0] addr;
        logic                       rd;        // 1 = read, 0 = write
        logic [`DDR_DATA_WIDTH-1:0] wr_data;
        logic [`DDR_STRB_WIDTH-1:0] wr_mask;
    } app_req_t;

    typedef struct packed {
        logic [`DDR_ID_WIDTH-1:0] id;
        logic                     last;
    } rd_tag_t;

    typedef struct packed {
        logic [`DDR_ID_WIDTH-1:0]   id;
        logic [`DDR_DATA_WIDTH-1:0] data;
        logic                       last;
    } rd_resp_t;

    typedef enum logic {ST_IDLE, ST_BUSY} fsm_state_t;

endpackage

/* sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic     ui_clk,
    input  logic     resetn,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // wraps for any depth
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head word is registered on the pop and held until the next one
    always_ff @(posedge ui_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

    a_no_overflow: assert property (@(posedge ui_clk) disable iff (!resetn)
        wr_en |-> !full)
        else $error("sync_fifo: push while full");

    a_no_underflow: assert property (@(posedge ui_clk) disable iff (!resetn)
        rd_en |-> !empty)
        else $error("sync_fifo: pop while empty");

endmodule

/* cmd_fetch.sv */
`timescale 1ns/1ps

module cmd_fetch (
    input  logic                     ui_clk,
    input  logic                     resetn,
    input  logic                     cmd_empty,
    input  ddr_bridge_pkg::app_cmd_t cmd_head,
    output logic                     cmd_pop,
    input  logic                     app_cmd_ready,
    input  logic                     app_wr_ready,
    input  logic                     tag_full,
    output logic                     app_cmd_en,
    output logic                     app_wr_en,
    output ddr_bridge_pkg::app_req_t app_req,
    output logic                     tag_push,
    output ddr_bridge_pkg::rd_tag_t  tag
);

    import ddr_bridge_pkg::*;

    fsm_state_t state;
    fsm_state_t state_next;
    logic       issue_ok;

    // reads wait for tag room, writes for the data path
    assign issue_ok = cmd_head.rd ? (app_cmd_ready && !tag_full)
                                  : (app_cmd_ready && app_wr_ready);

    assign app_req.addr    = cmd_head.addr;
    assign app_req.rd      = cmd_head.rd;
    assign app_req.wr_data = cmd_head.wr_data;
    assign app_req.wr_mask = cmd_head.wr_mask;

    assign tag.id   = cmd_head.id;
    assign tag.last = cmd_head.last;

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        cmd_pop    = 1'b0;
        app_cmd_en = 1'b0;
        app_wr_en  = 1'b0;
        tag_push   = 1'b0;
        case (state)
            ST_IDLE: begin
                if (!cmd_empty) begin
                    cmd_pop    = 1'b1;      // head valid next cycle
                    state_next = ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (issue_ok) begin
                    app_cmd_en = 1'b1;
                    app_wr_en  = !cmd_head.rd;
                    tag_push   = cmd_head.rd;
                    if (cmd_empty) begin
                        state_next = ST_IDLE;
                    end else begin
                        cmd_pop = 1'b1;     // fetch next while issuing
                    end
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // a waiting command holds until it is issued
    a_held_cmd_stable: assert property (@(posedge ui_clk) disable iff (!resetn)
        (state == ST_BUSY && !app_cmd_en) |=> $stable(app_req))
        else $error("cmd_fetch: held command changed before issue");

endmodule

/* rd_resp_merge.sv */
`timescale 1ns/1ps
`include "ddr_bridge_config.svh"

module rd_resp_merge (
    input  logic                            ui_clk,
    input  logic                            resetn,
    input  logic                            tag_empty,
    input  ddr_bridge_pkg::rd_tag_t         tag_head,
    input  logic                            data_empty,
    input  logic [`DDR_DATA_WIDTH-1:0]      data_head,
    output logic                            tag_pop,
    output logic                            data_pop,
    output ddr_bridge_pkg::rd_resp_t        rd_resp,
    output logic                            rd_resp_valid,
    input  logic                            rd_resp_ready
);

    import ddr_bridge_pkg::*;

    fsm_state_t state;
    fsm_state_t state_next;
    logic       pair_avail;
    logic       xfer;
    logic       pop;

    assign pair_avail = !tag_empty && !data_empty;
    assign xfer       = rd_resp_valid && rd_resp_ready;

    // fifo heads only move on a pop, so the response holds while stalled
    assign rd_resp.id   = tag_head.id;
    assign rd_resp.data = data_head;
    assign rd_resp.last = tag_head.last;

    assign rd_resp_valid = (state == ST_BUSY);
    assign tag_pop       = pop;
    assign data_pop      = pop;

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        pop        = 1'b0;
        case (state)
            ST_IDLE: begin
                if (pair_avail) begin
                    pop        = 1'b1;
                    state_next = ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (xfer) begin
                    if (pair_avail) begin
                        pop = 1'b1;         // reload behind the accepted beat
                    end else begin
                        state_next = ST_IDLE;
                    end
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    a_resp_stable: assert property (@(posedge ui_clk) disable iff (!resetn)
        (rd_resp_valid && !rd_resp_ready) |=> (rd_resp_valid && $stable(rd_resp)))
        else $error("rd_resp_merge: response changed under back-pressure");

endmodule

/* ddr_bridge_top.sv */
`timescale 1ns/1ps
`include "ddr_bridge_config.svh"

module ddr_bridge_top (
    input  logic                        ui_clk,
    input  logic                        resetn,
    input  ddr_bridge_pkg::ram_cmd_t    ram_cmd,
    input  logic                        ram_cmd_wr_en,
    input  logic                        ram_cmd_rd_en,
    output logic                        ram_cmd_ready,
    output ddr_bridge_pkg::rd_resp_t    rd_resp,
    output logic                        rd_resp_valid,
    input  logic                        rd_resp_ready,
    output ddr_bridge_pkg::app_req_t    app_req,
    output logic                        app_cmd_en,
    output logic                        app_wr_en,
    input  logic                        app_cmd_ready,
    input  logic                        app_wr_ready,
    input  logic [`DDR_DATA_WIDTH-1:0]  app_rd_data,
    input  logic                        app_rd_valid
);

    import ddr_bridge_pkg::*;

    app_cmd_t                   cmd_in;
    app_cmd_t                   cmd_head;
    logic                       cmd_push;
    logic                       cmd_pop;
    logic                       cmd_empty;
    logic                       cmd_full;
    rd_tag_t                    tag_in;
    rd_tag_t                    tag_head;
    logic                       tag_push;
    logic                       tag_pop;
    logic                       tag_empty;
    logic                       tag_full;
    logic [`DDR_DATA_WIDTH-1:0] data_head;
    logic                       data_pop;
    logic                       data_empty;
    logic                       data_full;

    // controller wants word address and an inverted byte mask
    assign cmd_in.id      = ram_cmd.id;
    assign cmd_in.addr    = ram_cmd.addr >> 1;
    assign cmd_in.wr_data = ram_cmd.wr_data;
    assign cmd_in.wr_mask = ~ram_cmd.wr_strb;
    assign cmd_in.rd      = ram_cmd_rd_en;
    assign cmd_in.last    = ram_cmd.last;

    assign cmd_push      = ram_cmd_wr_en || ram_cmd_rd_en;
    assign ram_cmd_ready = !cmd_full;

    sync_fifo #(.payload_t(app_cmd_t), .DEPTH(`DDR_CMD_FIFO_DEPTH)) cmd_q (
        .ui_clk(ui_clk), .resetn(resetn),
        .wr_en(cmd_push), .wr_data(cmd_in),
        .rd_en(cmd_pop), .rd_data(cmd_head),
        .empty(cmd_empty), .full(cmd_full)
    );

    cmd_fetch u_fetch (
        .ui_clk(ui_clk), .resetn(resetn),
        .cmd_empty(cmd_empty), .cmd_head(cmd_head), .cmd_pop(cmd_pop),
        .app_cmd_ready(app_cmd_ready), .app_wr_ready(app_wr_ready),
        .tag_full(tag_full),
        .app_cmd_en(app_cmd_en), .app_wr_en(app_wr_en), .app_req(app_req),
        .tag_push(tag_push), .tag(tag_in)
    );

    sync_fifo #(.payload_t(rd_tag_t), .DEPTH(`DDR_TAG_FIFO_DEPTH)) tag_q (
        .ui_clk(ui_clk), .resetn(resetn),
        .wr_en(tag_push), .wr_data(tag_in),
        .rd_en(tag_pop), .rd_data(tag_head),
        .empty(tag_empty), .full(tag_full)
    );

    sync_fifo #(
        .payload_t(logic [`DDR_DATA_WIDTH-1:0]),
        .DEPTH(`DDR_RD_FIFO_DEPTH)
    ) rd_data_q (
        .ui_clk(ui_clk), .resetn(resetn),
        .wr_en(app_rd_valid), .wr_data(app_rd_data),
        .rd_en(data_pop), .rd_data(data_head),
        .empty(data_empty), .full(data_full)
    );

    rd_resp_merge u_merge (
        .ui_clk(ui_clk), .resetn(resetn),
        .tag_empty(tag_empty), .tag_head(tag_head),
        .data_empty(data_empty), .data_head(data_head),
        .tag_pop(tag_pop), .data_pop(data_pop),
        .rd_resp(rd_resp), .rd_resp_valid(rd_resp_valid), .rd_resp_ready(rd_resp_ready)
    );

    a_cmd_protocol: assert property (@(posedge ui_clk) disable iff (!resetn)
        cmd_push |-> (ram_cmd_ready && !(ram_cmd_wr_en && ram_cmd_rd_en)))
        else $error("ddr_bridge_top: command strobe while not ready");

    // tag depth bounds outstanding reads, so returned data always has room
    a_rd_data_room: assert property (@(posedge ui_clk) disable iff (!resetn)
        app_rd_valid |-> !data_full)
        else $error("ddr_bridge_top: read data queue overflow");

endmodule

/* app_mem_model.sv */
`timescale 1ns/1ps
`include "ddr_bridge_config.svh"

module app_mem_model (
    input  logic                       ui_clk,
    input  logic                       resetn,
    input  logic                       throttle,
    input  ddr_bridge_pkg::app_req_t   app_req,
    input  logic                       app_cmd_en,
    input  logic                       app_wr_en,
    output logic                       app_cmd_ready,
    output logic                       app_wr_ready,
    output logic [`DDR_DATA_WIDTH-1:0] app_rd_data,
    output logic                       app_rd_valid
);

    localparam int RD_LATENCY = 4;

    logic [`DDR_DATA_WIDTH-1:0] mem [logic [`DDR_ADDR_WIDTH-1:0]];  // word addressed
    logic [RD_LATENCY-1:0]      pipe_v;
    logic [`DDR_DATA_WIDTH-1:0] pipe_d [RD_LATENCY];
    int                         hold_cnt;

    // never-written words read back as a pattern of their own address
    function automatic logic [`DDR_DATA_WIDTH-1:0] blank_word(
        input logic [`DDR_ADDR_WIDTH-1:0] waddr
    );
        return {waddr, ~waddr, waddr ^ 32'ha5a5_5a5a, waddr + 32'h1357_9bdf};
    endfunction

    function automatic logic [`DDR_DATA_WIDTH-1:0] stored_word(
        input logic [`DDR_ADDR_WIDTH-1:0] waddr
    );
        return mem.exists(waddr) ? mem[waddr] : blank_word(waddr);
    endfunction

    assign app_wr_ready = 1'b1;
    assign app_rd_valid = pipe_v[RD_LATENCY-1];
    assign app_rd_data  = pipe_d[RD_LATENCY-1];

    always @(posedge ui_clk) begin
        logic [`DDR_DATA_WIDTH-1:0] word;
        if (app_cmd_en && app_wr_en) begin
            word = stored_word(app_req.addr);
            for (int b = 0; b < `DDR_STRB_WIDTH; b++) begin
                if (!app_req.wr_mask[b]) begin
                    word[8*b +: 8] = app_req.wr_data[8*b +: 8];  // mask 0 = byte written
                end
            end
            mem[app_req.addr] = word;
        end
    end

    // fixed latency return, issue order kept by the shift
    always @(posedge ui_clk) begin
        if (!resetn) begin
            pipe_v <= '0;
        end else begin
            pipe_v <= {pipe_v[RD_LATENCY-2:0], app_cmd_en && app_req.rd};
        end
        if (app_cmd_en && app_req.rd) begin
            pipe_d[0] <= stored_word(app_req.addr);
        end
        for (int i = 1; i < RD_LATENCY; i++) begin
            pipe_d[i] <= pipe_d[i-1];
        end
    end

    always @(posedge ui_clk) begin
        if (!resetn || !throttle) begin
            app_cmd_ready <= 1'b1;
            hold_cnt      <= 0;
        end else if (hold_cnt == 0) begin
            app_cmd_ready <= !app_cmd_ready;               // flip for a random stretch
            hold_cnt      <= int'($urandom_range(6, 1));
        end else begin
            hold_cnt <= hold_cnt - 1;
        end
    end

endmodule

/* tb_ddr_bridge.sv */
`timescale 1ns/1ps
`include "ddr_bridge_config.svh"

module tb_ddr_bridge;

    import ddr_bridge_pkg::*;

    localparam int N_STREAM    = 24;
    localparam int N_BP        = 40;
    localparam int N_MIX       = 60;
    localparam int CYCLE_LIMIT = 280 + 30 * (N_STREAM + N_BP + N_MIX);  // about 30 cycles a command

    logic                       ui_clk = 1'b0;
    logic                       resetn;
    ram_cmd_t                   ram_cmd;
    logic                       ram_cmd_wr_en;
    logic                       ram_cmd_rd_en;
    logic                       ram_cmd_ready;
    rd_resp_t                   rd_resp;
    logic                       rd_resp_valid;
    logic                       rd_resp_ready;
    app_req_t                   app_req;
    logic                       app_cmd_en;
    logic                       app_wr_en;
    logic                       app_cmd_ready;
    logic                       app_wr_ready;
    logic [`DDR_DATA_WIDTH-1:0] app_rd_data;
    logic                       app_rd_valid;
    logic                       throttle;

    logic [`DDR_DATA_WIDTH-1:0] shadow [logic [`DDR_ADDR_WIDTH-1:0]];  // byte addr >> 1
    rd_resp_t                   expect_q [$];
    int                         errors = 0;
    int                         tests_passed = 0;
    int                         tests_failed = 0;
    int                         cycle_count = 0;

    ddr_bridge_top dut (.*);
    app_mem_model mem_model (.*);

    always #5 ui_clk = ~ui_clk;

    always @(posedge ui_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [`DDR_DATA_WIDTH-1:0] background_word(input logic [31:0] key);
        return {key, ~key, key ^ 32'ha5a5_5a5a, key + 32'h1357_9bdf};
    endfunction

    function automatic logic [`DDR_DATA_WIDTH-1:0] shadow_word(input logic [31:0] key);
        return shadow.exists(key) ? shadow[key] : background_word(key);
    endfunction

    function automatic logic [`DDR_DATA_WIDTH-1:0] rand_word();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic value_error(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        errors++;
        $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
    endtask

    task automatic flag_failure(input string what);
        errors++;
        $display("%0t: %s", $time, what);
    endtask

    task automatic wait_cmd_room();
        @(negedge ui_clk);
        while (!ram_cmd_ready) @(negedge ui_clk);
    endtask

    // one strobe cycle, shadow and scoreboard follow in send order
    task automatic issue_cmd(input logic is_rd, input logic [7:0] id, input logic [31:0] addr,
                             input logic [127:0] data, input logic [15:0] strb,
                             input logic last);
        logic [31:0]  key;
        logic [127:0] word;
        rd_resp_t     exp;
        key = addr >> 1;
        @(posedge ui_clk);
        ram_cmd       <= {id, addr, data, strb, is_rd, last};
        ram_cmd_rd_en <= is_rd;
        ram_cmd_wr_en <= !is_rd;
        if (is_rd) begin
            exp.id   = id;
            exp.data = shadow_word(key);
            exp.last = last;
            expect_q.push_back(exp);
        end else begin
            word = shadow_word(key);
            for (int b = 0; b < `DDR_STRB_WIDTH; b++) begin
                if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
            end
            shadow[key] = word;
        end
        @(posedge ui_clk);
        ram_cmd_rd_en <= 1'b0;
        ram_cmd_wr_en <= 1'b0;
    endtask

    task automatic send_cmd(input logic is_rd, input logic [7:0] id, input logic [31:0] addr,
                            input logic [127:0] data, input logic [15:0] strb,
                            input logic last);
        wait_cmd_room();
        issue_cmd(is_rd, id, addr, data, strb, last);
    endtask

    task automatic drain();
        while (expect_q.size() != 0) @(posedge ui_clk);
        repeat (12) @(posedge ui_clk);  // room for a stray response
    endtask

    task automatic finish_test(input int num, input string name, input int mark);
        if (errors == mark) begin
            tests_passed++;
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", num, name, errors - mark);
        end
    endtask

    always @(posedge ui_clk) begin
        rd_resp_t exp;
        if (resetn && rd_resp_valid && rd_resp_ready) begin
            if (expect_q.size() == 0) begin
                flag_failure("read response arrived with no read outstanding");
            end else begin
                exp = expect_q.pop_front();
                assert (rd_resp.id == exp.id)
                    else value_error("rd_resp.id", rd_resp.id, exp.id);
                assert (rd_resp.data == exp.data)
                    else value_error("rd_resp.data", rd_resp.data, exp.data);
                assert (rd_resp.last == exp.last)
                    else value_error("rd_resp.last", rd_resp.last, exp.last);
            end
        end
    end

    a_resp_hold: assert property (@(posedge ui_clk) disable iff (!resetn)
        (rd_resp_valid && !rd_resp_ready) |=> (rd_resp_valid && $stable(rd_resp)))
        else flag_failure("rd_resp changed or dropped while stalled");

    a_issue_ready: assert property (@(posedge ui_clk) disable iff (!resetn)
        app_cmd_en |-> app_cmd_ready)
        else flag_failure("command issued while app_cmd_ready was low");

    a_wr_pairing: assert property (@(posedge ui_clk) disable iff (!resetn)
        app_wr_en |-> (app_cmd_en && !app_req.rd))
        else flag_failure("app_wr_en raised without a write command");

    a_strobe_ready: assert property (@(posedge ui_clk) disable iff (!resetn)
        (ram_cmd_wr_en || ram_cmd_rd_en) |-> ram_cmd_ready)
        else flag_failure("command strobe raised while ram_cmd_ready was low");

    initial begin
        int           mark;
        logic         saw_full;
        logic         is_rd;
        logic [31:0]  addr;
        logic [127:0] data;
        void'($urandom(32'he47f9d13));
        resetn        = 1'b0;
        ram_cmd       = '0;
        ram_cmd_wr_en = 1'b0;
        ram_cmd_rd_en = 1'b0;
        rd_resp_ready = 1'b1;
        throttle      = 1'b0;
        repeat (8) @(posedge ui_clk);
        resetn <= 1'b1;

        mark = errors;
        @(negedge ui_clk);
        assert (!rd_resp_valid) else value_error("rd_resp_valid", rd_resp_valid, 1'b0);
        assert (!app_cmd_en) else value_error("app_cmd_en", app_cmd_en, 1'b0);
        assert (!app_wr_en) else value_error("app_wr_en", app_wr_en, 1'b0);
        assert (ram_cmd_ready) else value_error("ram_cmd_ready", ram_cmd_ready, 1'b1);
        finish_test(1, "reset state", mark);

        mark = errors;
        send_cmd(1'b0, 8'h11, 32'h0000_0240, rand_word(), 16'hffff, 1'b1);
        send_cmd(1'b1, 8'h22, 32'h0000_0240, '0, '0, 1'b1);
        drain();
        finish_test(2, "write then read", mark);

        mark = errors;
        send_cmd(1'b0, 8'h31, 32'h0000_0380, rand_word(), 16'hffff, 1'b1);
        send_cmd(1'b0, 8'h32, 32'h0000_0380, rand_word(), 16'ha53c, 1'b1);
        send_cmd(1'b1, 8'h33, 32'h0000_0380, '0, '0, 1'b0);
        drain();
        finish_test(3, "partial strobe merge", mark);

        mark = errors;
        for (int i = 0; i < N_STREAM; i++) begin
            addr = $urandom() & 32'h0000_fff0;
            send_cmd(1'b1, 8'($urandom()), addr, '0, '0, 1'($urandom()));
        end
        drain();
        finish_test(4, "read stream", mark);

        mark = errors;
        saw_full = 1'b0;
        @(posedge ui_clk);
        throttle      <= 1'b1;
        rd_resp_ready <= 1'b0;
        for (int i = 0; i < N_BP && !saw_full; i++) begin
            @(negedge ui_clk);
            if (!ram_cmd_ready) begin
                saw_full = 1'b1;
            end else begin
                addr = $urandom() & 32'h0000_fff0;
                issue_cmd(1'b1, 8'($urandom()), addr, '0, '0, 1'($urandom()));
            end
        end
        if (!saw_full) flag_failure("ram_cmd_ready never dropped under back-pressure");
        repeat (20) @(posedge ui_clk);
        rd_resp_ready <= 1'b1;
        drain();
        throttle <= 1'b0;
        finish_test(5, "back-pressure", mark);

        mark = errors;
        for (int i = 0; i < N_MIX; i++) begin
            is_rd = 1'($urandom());
            addr  = 32'h0000_1000 + (($urandom() % 16) << 4);  // small pool, frequent hits
            data  = rand_word();
            send_cmd(is_rd, 8'($urandom()), addr, data, 16'($urandom()), 1'($urandom()));
        end
        drain();
        finish_test(6, "mixed traffic", mark);

        $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
ddr_bridge_pkg.sv
sync_fifo.sv
cmd_fetch.sv
rd_resp_merge.sv
ddr_bridge_top.sv
app_mem_model.sv
tb_ddr_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ddr_bridge
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
